// File: bin_frame_store.sv
`timescale 1ns/1ps

module bin_frame_store #(
	parameter int bin_count = 16
) (
	input logic clk,
	input logic rst,
	input logic bin_valid,
	input fas_pkg::bin_word_u bin,
	output logic frame_load,
	output logic [bin_count*fas_pkg::bin_w-1:0] frame
);

	localparam int idx_w = $clog2(bin_count);
	localparam int bw = fas_pkg::bin_w;
	localparam logic [idx_w-1:0] last_idx = idx_w'(bin_count - 1);

	logic [idx_w-1:0] wr_idx;
	fas_pkg::bin_word_u coll [bin_count-1];	// last bin goes straight to the frame

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			wr_idx <= '0;
			frame_load <= 1'b0;
			frame <= '0;
			for (int i = 0; i < bin_count - 1; i++) begin
				coll[i] <= '0;
			end
		end else begin
			frame_load <= bin_valid && (wr_idx == last_idx);
			if (bin_valid) begin
				wr_idx <= wr_idx + 1'b1;	// wraps to start the next frame
				if (wr_idx != last_idx) begin
					coll[wr_idx] <= bin;
				end else begin
					// hand over the whole frame, collection restarts at once
					for (int i = 0; i < bin_count - 1; i++) begin
						frame[i*bw +: bw] <= coll[i].raw;
					end
					frame[(bin_count-1)*bw +: bw] <= bin.raw;
				end
			end
		end
	end

endmodule

// File: fas_checker.sv
`timescale 1ns/1ps

module fas_checker #(
	parameter int bin_count = 16
) (
	input logic clk,
	input logic rst,
	input logic data_valid,
	input logic fir_valid,
	input logic frame_load,
	input logic done
);

	logic [7:0] n_acc;	// accepted samples, stops past the warm-up

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			n_acc <= '0;
		end else if (data_valid && n_acc <= 8'(fas_pkg::fir_taps)) begin
			n_acc <= n_acc + 1'b1;
		end
	end

	done_one_cycle: assert property (@(posedge clk) disable iff (rst) done |=> !done)
		else $error("done stayed high for more than one cycle");

	// output only with a sample and only once 33 samples are in
	fir_valid_rule: assert property (@(posedge clk) disable iff (rst)
		fir_valid == (data_valid && n_acc > fas_pkg::fir_taps))
		else $error("fir_valid disagrees with data_valid and the warm-up count");

	// each done closes the search loaded bin_count+1 edges before
	no_early_done: assert property (@(posedge clk) disable iff (rst)
		done |-> $past(frame_load, bin_count + 1))
		else $error("done came without a frame_load bin_count+1 cycles earlier");

endmodule

bind fas_top fas_checker #(.bin_count(bin_count)) fas_checker_i (
	.clk (clk),
	.rst (rst),
	.data_valid (data_valid),
	.fir_valid (fir_valid),
	.frame_load (frame_load),
	.done (done)
);

// File: fas_pkg.sv
package fas_pkg;

	localparam int sample_w = 16;	// input and filter output samples
	localparam int acc_w = 32;	// products and adder tree
	localparam int fir_taps = 32;
	localparam int fir_half = fir_taps / 2;	// one coefficient per mirrored pair

	// outermost pair first, centre pair last
	localparam logic signed [sample_w-1:0] fir_coef [fir_half] = '{
		16'hFF9E,
		16'hFF86,
		16'hFFA7,
		16'h003B,
		16'h014B,
		16'h024A,
		16'h0222,
		16'hFFE4,
		16'hFBC5,
		16'hF7CA,
		16'hF74E,
		16'hFD74,
		16'h0B1A,
		16'h1DAC,
		16'h2F9E,
		16'h3AA9	// centre pair, largest weight
	};

	localparam int bin_w = 32;
	localparam int part_w = bin_w / 2;
	localparam int power_w = 2 * part_w + 1;	// re^2 + im^2 without wrap

	typedef struct packed {
		logic signed [part_w-1:0] re;	// upper half
		logic signed [part_w-1:0] im;	// lower half
	} bin_parts_s;

	// same 32 bits seen as a flat word or as complex parts
	typedef union packed {
		logic [bin_w-1:0] raw;
		bin_parts_s parts;
	} bin_word_u;

endpackage

// File: fas_top.sv
`timescale 1ns/1ps

module fas_top #(
	parameter int bin_count = 16
) (
	input logic clk,
	input logic rst,
	input logic data_valid,
	input logic [fas_pkg::sample_w-1:0] data,
	output logic fir_valid,
	output logic [fas_pkg::sample_w-1:0] fir_d,
	input logic bin_valid,
	input fas_pkg::bin_word_u bin,
	output logic done,
	output logic [$clog2(bin_count)-1:0] freq
);

	logic [fas_pkg::fir_taps*fas_pkg::sample_w-1:0] taps;	// tap 0 newest
	logic frame_load;
	logic [bin_count*fas_pkg::bin_w-1:0] frame;

	fir_tap_line fir_tap_line_i (
		.clk (clk),
		.rst (rst),
		.data_valid (data_valid),
		.data (data),
		.taps (taps),
		.fir_valid (fir_valid)
	);

	fir_mac fir_mac_i (
		.taps (taps),
		.fir_d (fir_d)
	);

	// analysis path, independent of the filter apart from clk and rst
	bin_frame_store #(.bin_count(bin_count)) bin_frame_store_i (
		.clk (clk),
		.rst (rst),
		.bin_valid (bin_valid),
		.bin (bin),
		.frame_load (frame_load),
		.frame (frame)
	);

	peak_search #(.bin_count(bin_count)) peak_search_i (
		.clk (clk),
		.rst (rst),
		.frame_load (frame_load),
		.frame (frame),
		.done (done),
		.freq (freq)
	);

endmodule

// File: files.f
fas_pkg.sv
fir_tap_line.sv
fir_mac.sv
bin_frame_store.sv
peak_search.sv
fas_top.sv
tb_clock_gen.sv
fas_checker.sv
tb_fas.sv

// File: fir_mac.sv
`timescale 1ns/1ps

module fir_mac (
	input logic [fas_pkg::fir_taps*fas_pkg::sample_w-1:0] taps,
	output logic [fas_pkg::sample_w-1:0] fir_d
);

	localparam int sw = fas_pkg::sample_w;
	localparam int half = fas_pkg::fir_half;

	logic signed [sw:0] pre [half];	// pair sum, one bit wider
	logic signed [fas_pkg::acc_w-1:0] node [1:2*half-1];	// heap-ordered adder tree
	logic signed [fas_pkg::acc_w-1:0] sum;

	// pre-add each mirrored pair then weight it
	for (genvar k = 0; k < half; k++) begin : g_pair
		logic signed [sw-1:0] tap_near;
		logic signed [sw-1:0] tap_far;

		assign tap_near = taps[k*sw +: sw];
		assign tap_far = taps[(fas_pkg::fir_taps-1-k)*sw +: sw];
		assign pre[k] = tap_near + tap_far;
		assign node[half+k] = pre[k] * fas_pkg::fir_coef[k];	// leaves of the tree
	end

	// node n adds its two children, four levels down to node 1
	for (genvar n = 1; n < half; n++) begin : g_tree
		assign node[n] = node[2*n] + node[2*n+1];
	end

	assign sum = node[1];

	// keep the upper half, negative sums step one toward zero
	always_comb begin
		if (sum[fas_pkg::acc_w-1]) begin
			fir_d = sum[fas_pkg::acc_w-1 -: sw] + 1'b1;
		end else begin
			fir_d = sum[fas_pkg::acc_w-1 -: sw];
		end
	end

endmodule

// File: fir_tap_line.sv
`timescale 1ns/1ps

module fir_tap_line (
	input logic clk,
	input logic rst,
	input logic data_valid,
	input logic [fas_pkg::sample_w-1:0] data,
	output logic [fas_pkg::fir_taps*fas_pkg::sample_w-1:0] taps,
	output logic fir_valid
);

	localparam int warm_max = fas_pkg::fir_taps + 1;	// line full plus one sample
	localparam int cnt_w = $clog2(warm_max + 1);
	localparam int line_w = fas_pkg::fir_taps * fas_pkg::sample_w;

	logic [cnt_w-1:0] warm_cnt;
	logic warm_done;

	assign warm_done = (warm_cnt == cnt_w'(warm_max));

	// counts accepted samples, stops once the output may start
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			warm_cnt <= '0;
		end else if (data_valid && !warm_done) begin
			warm_cnt <= warm_cnt + 1'b1;
		end
	end

	// newest sample enters at tap 0, oldest falls off tap 31
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			taps <= '0;
		end else if (data_valid) begin
			taps <= {taps[line_w-fas_pkg::sample_w-1:0], data};
		end
	end

	// output belongs to the sample arriving now, filter uses the 32 before it
	assign fir_valid = data_valid && warm_done;

endmodule

// File: peak_search.sv
`timescale 1ns/1ps

module peak_search #(
	parameter int bin_count = 16
) (
	input logic clk,
	input logic rst,
	input logic frame_load,
	input logic [bin_count*fas_pkg::bin_w-1:0] frame,
	output logic done,
	output logic [$clog2(bin_count)-1:0] freq
);

	localparam int idx_w = $clog2(bin_count);
	localparam int bw = fas_pkg::bin_w;
	localparam logic [idx_w-1:0] last_idx = idx_w'(bin_count - 1);

	fas_pkg::bin_word_u frame_q [bin_count];	// frame under search
	fas_pkg::bin_word_u cur;
	logic signed [2*fas_pkg::part_w-1:0] re_sq;
	logic signed [2*fas_pkg::part_w-1:0] im_sq;
	logic [fas_pkg::power_w-1:0] power;
	logic [fas_pkg::power_w-1:0] max_pow;
	logic [idx_w-1:0] max_idx;
	logic [idx_w-1:0] idx;
	logic busy;
	logic better;

	always_ff @(posedge clk) begin
		if (frame_load) begin
			for (int i = 0; i < bin_count; i++) begin
				frame_q[i].raw <= frame[i*bw +: bw];
			end
		end
	end

	assign cur = frame_q[idx];
	assign re_sq = cur.parts.re * cur.parts.re;
	assign im_sq = cur.parts.im * cur.parts.im;
	assign power = {1'b0, re_sq} + {1'b0, im_sq};	// both squares are non-negative
	assign better = power > max_pow;	// strict compare keeps the lower index on a tie

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			busy <= 1'b0;
			idx <= '0;
			max_pow <= '0;
			max_idx <= '0;
			done <= 1'b0;
			freq <= '0;
		end else begin
			done <= 1'b0;
			// last bin still scores when the next frame loads on this edge
			if (busy && idx == last_idx) begin
				done <= 1'b1;
				freq <= better ? idx : max_idx;	// held until the next done
			end
			if (frame_load) begin	// a new frame aborts any running search
				busy <= 1'b1;
				idx <= '0;
				max_pow <= '0;
				max_idx <= '0;
			end else if (busy) begin
				if (better) begin
					max_pow <= power;
					max_idx <= idx;
				end
				idx <= idx + 1'b1;
				if (idx == last_idx) begin
					busy <= 1'b0;
				end
			end
		end
	end

endmodule

// File: run_sim.sh
#!/bin/sh
# build and run the fas testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_fas \
	-f files.f --Mdir obj_dir -o tb_fas_sim
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/tb_fas_sim > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
	echo "simulation exited with status $run_status"
	exit 1
fi

if grep -qx "Regression passed" sim.log; then
	exit 0
fi
echo "pass message not found in sim.log"
exit 1

// File: tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
	parameter int period_ns = 100,
	parameter int reset_cycles = 10
) (
	output logic clk,
	output logic rst
);

	initial begin
		clk = 1'b0;
		forever #(period_ns / 2) clk = ~clk;
	end

	initial begin
		rst = 1'b1;
		repeat (reset_cycles) @(posedge clk);
		rst <= 1'b0;	// released on a rising edge
	end

endmodule

// File: tb_fas.sv
`timescale 1ns/1ps

module tb_fas;

	localparam int bin_count = 16;
	localparam int idx_w = $clog2(bin_count);
	localparam int period_ns = 100;
	localparam int taps = fas_pkg::fir_taps;
	localparam int n_warm = 60;
	localparam int n_rand = 400;
	localparam int n_frames = 13;
	// worst case with every warm-up sample gapped and a long idle after each frame
	localparam int test_cycles = 2 * n_warm + n_rand + 4 * taps + n_frames * (2 * bin_count + 4);
	localparam int limit_cycles = test_cycles + 10 + 200;	// reset plus margin

	logic clk;
	logic rst;
	logic data_valid;
	logic [fas_pkg::sample_w-1:0] data;
	logic fir_valid;
	logic [fas_pkg::sample_w-1:0] fir_d;
	logic bin_valid;
	fas_pkg::bin_word_u bin;
	logic done;
	logic [idx_w-1:0] freq;

	integer seed;
	logic [31:0] stim_frame [bin_count];	// frame being sent
	logic signed [15:0] hist [taps] = '{default: '0};	// accepted samples with newest first
	logic [31:0] frame_m [bin_count];	// frame as seen on the bin port
	int accepted = 0;
	int bin_idx = 0;
	int due_q [$];	// negedge number where each done is due
	int freq_q [$];
	int ncycle = 0;
	int fir_checks = 0;
	int fir_errors = 0;
	int peak_checks = 0;
	int peak_errors = 0;
	int other_errors = 0;

	tb_clock_gen #(.period_ns(period_ns), .reset_cycles(10)) tb_clock_gen_i (
		.clk (clk),
		.rst (rst)
	);

	fas_top #(.bin_count(bin_count)) fas_top_i (
		.clk (clk),
		.rst (rst),
		.data_valid (data_valid),
		.data (data),
		.fir_valid (fir_valid),
		.fir_d (fir_d),
		.bin_valid (bin_valid),
		.bin (bin),
		.done (done),
		.freq (freq)
	);

	// tap k and tap 31-k share coefficient k and the sum wraps at 32 bits
	function automatic logic [15:0] fir_ref(input logic signed [15:0] h [taps]);
		longint acc;
		logic [31:0] s;
		int c;
		acc = 0;
		for (int k = 0; k < taps; k++) begin
			c = (k < fas_pkg::fir_half) ? k : taps - 1 - k;
			acc += longint'(h[k]) * longint'(fas_pkg::fir_coef[c]);
		end
		s = acc[31:0];
		return s[31:16] + (s[31] ? 16'd1 : 16'd0);	// toward zero
	endfunction

	function automatic int peak_ref(input logic [31:0] f [bin_count]);
		longint best;
		longint p;
		int best_i;
		logic signed [15:0] re;
		logic signed [15:0] im;
		best = 0;
		best_i = 0;
		for (int i = 0; i < bin_count; i++) begin
			re = f[i][31:16];
			im = f[i][15:0];
			p = longint'(re) * longint'(re) + longint'(im) * longint'(im);
			if (p > best) begin	// first maximum wins
				best = p;
				best_i = i;
			end
		end
		return best_i;
	endfunction

	task automatic send_sample(input logic [15:0] s);
		@(posedge clk);
		data_valid <= 1'b1;
		data <= s;
	endtask

	task automatic sample_idle(input int n);
		repeat (n) begin
			@(posedge clk);
			data_valid <= 1'b0;
		end
	endtask

	task automatic send_frame();
		for (int i = 0; i < bin_count; i++) begin
			@(posedge clk);
			bin_valid <= 1'b1;
			bin <= stim_frame[i];
		end
	endtask

	task automatic bin_idle(input int n);
		repeat (n) begin
			@(posedge clk);
			bin_valid <= 1'b0;
		end
	endtask

	task automatic fill_small();
		logic [31:0] r;
		for (int i = 0; i < bin_count; i++) begin
			r = $random(seed);
			stim_frame[i] = {{8{r[7]}}, r[7:0], {8{r[15]}}, r[15:8]};
		end
	endtask

	task automatic end_run();
		if (due_q.size() != 0) begin
			other_errors++;
			$display("%0d expected done pulses never arrived", due_q.size());
		end
		$display("fir checks %0d, fir errors %0d, peak checks %0d, peak errors %0d, other errors %0d",
			fir_checks, fir_errors, peak_checks, peak_errors, other_errors);
		if (fir_errors + peak_errors + other_errors == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	endtask

	// model and compare on the falling edge where inputs and outputs are settled
	always @(negedge clk) begin
		logic exp_valid;
		logic exp_done;
		logic [15:0] exp_d;
		if (!rst) begin
			ncycle++;
			exp_valid = data_valid && (accepted > taps);
			if (fir_valid !== exp_valid) begin
				other_errors++;
				$display("%0t: fir_valid is %b after %0d accepted samples", $time, fir_valid, accepted);
			end else if (exp_valid) begin
				fir_checks++;
				exp_d = fir_ref(hist);
				if (fir_d !== exp_d) begin
					fir_errors++;
					$display("Mismatch at %0t: fir_d expected %h got %h", $time, exp_d, fir_d);
				end
			end
			if (data_valid) begin
				for (int k = taps - 1; k > 0; k--) hist[k] = hist[k-1];
				hist[0] = data;
				accepted++;
			end
			exp_done = (due_q.size() > 0) && (due_q[0] == ncycle);
			if (done !== exp_done) begin
				other_errors++;
				$display("%0t: done is %b where %b was expected", $time, done, exp_done);
			end else if (exp_done) begin
				peak_checks++;
				if (freq !== idx_w'(freq_q[0])) begin
					peak_errors++;
					$display("Mismatch at %0t: freq expected %0d got %0d", $time, freq_q[0], freq);
				end
			end
			if (exp_done) begin
				void'(due_q.pop_front());
				void'(freq_q.pop_front());
			end
			if (bin_valid) begin
				frame_m[bin_idx] = bin.raw;
				bin_idx++;
				if (bin_idx == bin_count) begin
					bin_idx = 0;
					// an older search still running after the new load loses its result
					if (due_q.size() > 0 && due_q[due_q.size()-1] > ncycle + 2) begin
						void'(due_q.pop_back());
						void'(freq_q.pop_back());
					end
					due_q.push_back(ncycle + bin_count + 2);
					freq_q.push_back(peak_ref(frame_m));
				end
			end
		end
	end

	initial begin
		#(limit_cycles * period_ns);
		other_errors++;
		$display("Timeout: run did not finish within %0d cycles", limit_cycles);
		end_run();
	end

	initial begin
		seed = 32'ha359;
		data_valid = 1'b0;
		data = '0;
		bin_valid = 1'b0;
		bin = '0;
		@(negedge rst);
		for (int i = 0; i < n_warm; i++) begin	// warm-up with random gaps
			if ($random(seed) & 1) begin
				sample_idle(1);
			end
			send_sample(16'($random(seed)));
		end
		repeat (n_rand) send_sample(16'($random(seed)));
		repeat (taps) send_sample('0);
		send_sample(16'h7fff);	// impulse walks through every tap
		repeat (taps) send_sample('0);
		send_sample(16'h8000);
		repeat (taps + 1) send_sample('0);
		sample_idle(1);
		for (int f = 0; f < 4; f++) begin	// one strong bin at a random index
			fill_small();
			stim_frame[$unsigned($random(seed)) % bin_count] =
				{16'h4000 | 16'($random(seed) & 'hfff), 16'hc000};
			send_frame();
			bin_idle(bin_count + 4);
		end
		stim_frame = '{default: 32'h8000_8000};	// largest power everywhere
		send_frame();
		bin_idle(bin_count + 4);
		stim_frame = '{default: '0};
		stim_frame[5] = {16'd300, 16'd0};
		stim_frame[11] = {16'd0, 16'hfed4};	// im = -300
		send_frame();
		bin_idle(bin_count + 4);
		stim_frame = '{default: '0};
		stim_frame[2] = {16'd180, 16'd240};
		stim_frame[3] = {16'd240, 16'hff4c};	// im = -180
		stim_frame[9] = {16'hff4c, 16'd240};
		send_frame();
		bin_idle(bin_count + 4);
		stim_frame = '{default: '0};
		send_frame();
		bin_idle(bin_count + 4);
		for (int f = 0; f < 2; f++) begin	// one idle cycle between frames
			fill_small();
			send_frame();
			bin_idle(1);
		end
		bin_idle(bin_count + 4);
		for (int f = 0; f < 3; f++) begin	// back to back
			fill_small();
			stim_frame[f * 5] = {16'h5000, 16'd0};
			send_frame();
		end
		bin_idle(1);
		while (due_q.size() > 0) bin_idle(1);
		bin_idle(2);
		end_run();
	end

endmodule
